// ==== verilog/ecfg_pkg.sv ====
`default_nettype none

package ecfg_pkg;

   // ######################################
   // address map
   // ######################################

   // register index field sits in mi_addr[6:2]
   localparam int ecfg_rfaw = 5;              // 32 registers per group

   // group codes matched against mi_addr[19:16]
   localparam logic [3:0] group_base = 4'h0;   // core config block
   localparam logic [3:0] group_tx   = 4'h1;   // transmit block
   localparam logic [3:0] group_rx   = 4'h2;   // receive block

   // ######################################
   // reset values
   // ######################################

   localparam logic [11:0] default_coreid  = 12'h808;  // row 8 and col 2
   localparam logic [15:0] default_version = 16'h0000;

   // packet counter stops here
   localparam logic [15:0] count_max = 16'hffff;

   // ######################################
   // register indices
   // ######################################

   // base block registers
   typedef enum logic [ecfg_rfaw-1:0] {
      el_reset   = 5'd0,   // soft reset bit
      el_clk     = 5'd1,   // clock settings
      el_chipid  = 5'd2,   // core id
      el_version = 5'd3    // version word
   } base_reg_e;

   // tx and rx blocks share this layout
   typedef enum logic [ecfg_rfaw-1:0] {
      link_cfg  = 5'd0,    // enable and mode bits
      link_stat = 5'd1     // counter or error flags
   } link_reg_e;

endpackage

`default_nettype wire

// ==== verilog/ecfg_base.sv ====
`default_nettype none

module ecfg_base import ecfg_pkg::*; (
   input  wire logic        mi_clk,
   input  wire logic        hard_reset,     // only reset for the config regs
   input  wire logic        mi_en,
   input  wire logic        mi_we,          // full 32-bit word writes
   input  wire logic [19:0] mi_addr,        // unshifted byte address
   input  wire logic [31:0] mi_din,
   output logic      [31:0] rd_data,        // registered readback
   output logic             soft_reset,
   output logic      [15:0] clk_settings,
   output logic      [3:0]  colid,
   output logic      [3:0]  rowid
);

   // register storage
   logic        reset_reg;
   logic [15:0] clk_reg;
   logic [11:0] coreid_reg;
   logic [15:0] version_reg;

   // decode
   logic        group_hit;
   logic        base_write;
   logic        base_read;
   base_reg_e   reg_idx;

   logic        reset_write;
   logic        clk_write;
   logic        coreid_write;
   logic        version_write;

   // ######################################
   // address decode
   // ######################################

   assign group_hit  = (mi_addr[19:16] == group_base);
   assign base_write = mi_en &  mi_we & group_hit;
   assign base_read  = mi_en & ~mi_we & group_hit;

   // word index within the group
   assign reg_idx = base_reg_e'(mi_addr[ecfg_rfaw+1:2]);

   assign reset_write   = base_write & (reg_idx == el_reset);
   assign clk_write     = base_write & (reg_idx == el_clk);
   assign coreid_write  = base_write & (reg_idx == el_chipid);
   assign version_write = base_write & (reg_idx == el_version);

   // ######################################
   // config registers
   // ######################################

   // soft reset from bit 0 only
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         reset_reg <= 1'b0;
      end else if (reset_write) begin
         reset_reg <= mi_din[0];
      end
   end

   // clock settings for the pll
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         clk_reg <= 16'd0;
      end else if (clk_write) begin
         clk_reg <= mi_din[15:0];
      end
   end

   // core id comes up at the default mesh position
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         coreid_reg <= default_coreid;
      end else if (coreid_write) begin
         coreid_reg <= mi_din[11:0];
      end
   end

   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         version_reg <= default_version;
      end else if (version_write) begin
         version_reg <= mi_din[15:0];
      end
   end

   // control outputs straight from the regs
   assign soft_reset   = reset_reg;
   assign clk_settings = clk_reg;
   assign colid        = coreid_reg[5:2];    // column field
   assign rowid        = coreid_reg[11:8];   // row field

   // ######################################
   // readback
   // ######################################

   // one cycle read latency and held until the next base read
   always_ff @(posedge mi_clk) begin
      if (base_read) begin
         case (reg_idx)
            el_reset:   rd_data <= {31'd0, reset_reg};
            el_clk:     rd_data <= {16'd0, clk_reg};       // all 16 bits
            el_chipid:  rd_data <= {20'd0, coreid_reg};
            el_version: rd_data <= {16'd0, version_reg};
            default:    rd_data <= 32'd0;                  // unused index
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ecfg_tx.sv ====
`default_nettype none

module ecfg_tx import ecfg_pkg::*; (
   input  wire logic        mi_clk,
   input  wire logic        hard_reset,
   input  wire logic        mi_en,
   input  wire logic        mi_we,
   input  wire logic [19:0] mi_addr,
   input  wire logic [31:0] mi_din,
   input  wire logic        tx_pkt,        // one pulse per packet sent
   output logic      [31:0] rd_data,
   output logic             tx_enable,
   output logic      [3:0]  tx_mode
);

   logic        group_hit;
   logic        tx_write;
   logic        tx_read;
   link_reg_e   reg_idx;

   logic        cfg_write;
   logic        stat_write;

   logic        enable_reg;
   logic [3:0]  mode_reg;
   logic [15:0] pkt_count;
   logic        count_full;

   // ######################################
   // address decode
   // ######################################

   assign group_hit = (mi_addr[19:16] == group_tx);
   assign tx_write  = mi_en &  mi_we & group_hit;
   assign tx_read   = mi_en & ~mi_we & group_hit;

   assign reg_idx = link_reg_e'(mi_addr[ecfg_rfaw+1:2]);

   assign cfg_write  = tx_write & (reg_idx == link_cfg);
   assign stat_write = tx_write & (reg_idx == link_stat);   // clears counter

   // ######################################
   // link config
   // ######################################

   // enable in bit 0 and mode in 7:4
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         enable_reg <= 1'b0;
         mode_reg   <= 4'd0;
      end else if (cfg_write) begin
         enable_reg <= mi_din[0];
         mode_reg   <= mi_din[7:4];
      end
   end

   assign tx_enable = enable_reg;
   assign tx_mode   = mode_reg;

   // ######################################
   // packet counter
   // ######################################

   assign count_full = (pkt_count == count_max);

   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         pkt_count <= 16'd0;
      end else if (stat_write) begin
         // a packet in the clear cycle still counts
         pkt_count <= {15'd0, tx_pkt};
      end else if (tx_pkt && !count_full) begin
         pkt_count <= pkt_count + 16'd1;
      end
   end

   // ######################################
   // readback
   // ######################################

   always_ff @(posedge mi_clk) begin
      if (tx_read) begin
         case (reg_idx)
            link_cfg:  rd_data <= {24'd0, mode_reg, 3'd0, enable_reg};  // bits in place
            link_stat: rd_data <= {16'd0, pkt_count};  // count before this edge
            default:   rd_data <= 32'd0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ecfg_rx.sv ====
`default_nettype none

module ecfg_rx import ecfg_pkg::*; (
   input  wire logic        mi_clk,
   input  wire logic        hard_reset,
   input  wire logic        mi_en,
   input  wire logic        mi_we,
   input  wire logic [19:0] mi_addr,
   input  wire logic [31:0] mi_din,
   input  wire logic [7:0]  rx_error,      // error pulses from the receiver
   output logic      [31:0] rd_data,
   output logic             rx_enable,
   output logic      [2:0]  rx_mode
);

   logic        group_hit;
   logic        rx_write;
   logic        rx_read;
   link_reg_e   reg_idx;

   logic        cfg_write;
   logic        stat_write;

   logic        enable_reg;
   logic [2:0]  mode_reg;
   logic [7:0]  err_flags;      // sticky
   logic [7:0]  clr_mask;

   // ######################################
   // address decode
   // ######################################

   assign group_hit = (mi_addr[19:16] == group_rx);
   assign rx_write  = mi_en &  mi_we & group_hit;
   assign rx_read   = mi_en & ~mi_we & group_hit;

   assign reg_idx = link_reg_e'(mi_addr[ecfg_rfaw+1:2]);

   assign cfg_write  = rx_write & (reg_idx == link_cfg);
   assign stat_write = rx_write & (reg_idx == link_stat);

   // ######################################
   // link config
   // ######################################

   // enable in bit 0 and mode in 3:1
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         enable_reg <= 1'b0;
         mode_reg   <= 3'd0;
      end else if (cfg_write) begin
         enable_reg <= mi_din[0];
         mode_reg   <= mi_din[3:1];
      end
   end

   assign rx_enable = enable_reg;
   assign rx_mode   = mode_reg;

   // ######################################
   // error status
   // ######################################

   // write one to clear
   assign clr_mask = stat_write ? mi_din[7:0] : 8'd0;

   // new pulse beats a clear in the same cycle
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         err_flags <= 8'd0;
      end else begin
         err_flags <= (err_flags & ~clr_mask) | rx_error;
      end
   end

   // ######################################
   // readback
   // ######################################

   always_ff @(posedge mi_clk) begin
      if (rx_read) begin
         case (reg_idx)
            link_cfg:  rd_data <= {28'd0, mode_reg, enable_reg};
            link_stat: rd_data <= {24'd0, err_flags};
            default:   rd_data <= 32'd0;   // unused index
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ecfg_mi_mux.sv ====
`default_nettype none

module ecfg_mi_mux import ecfg_pkg::*; (
   input  wire logic        mi_clk,
   input  wire logic        hard_reset,
   input  wire logic        mi_en,
   input  wire logic        mi_we,
   input  wire logic [19:0] mi_addr,      // only the group field matters here
   input  wire logic [31:0] base_data,
   input  wire logic [31:0] tx_data,
   input  wire logic [31:0] rx_data,
   output logic      [31:0] mi_dout
);

   logic       mi_read;
   logic [1:0] rd_sel;      // 2'b11 means no block claimed the read

   assign mi_read = mi_en & ~mi_we;

   // ######################################
   // group of the last read
   // ######################################

   // captured on the same edge the block registers its rd_data
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         rd_sel <= 2'b11;
      end else if (mi_read) begin
         case (mi_addr[19:16])
            group_base: rd_sel <= group_base[1:0];
            group_tx:   rd_sel <= group_tx[1:0];
            group_rx:   rd_sel <= group_rx[1:0];
            default:    rd_sel <= 2'b11;   // unclaimed group
         endcase
      end
   end

   // combined with no extra cycle
   always_comb begin
      case (rd_sel)
         group_base[1:0]: mi_dout = base_data;
         group_tx[1:0]:   mi_dout = tx_data;
         group_rx[1:0]:   mi_dout = rx_data;
         default:         mi_dout = 32'd0;    // reads as zero
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/ecfg_top.sv ====
`default_nettype none

module ecfg_top (
   input  wire logic        mi_clk,
   input  wire logic        hard_reset,
   // simple memory interface
   input  wire logic        mi_en,
   input  wire logic        mi_we,
   input  wire logic [19:0] mi_addr,
   input  wire logic [31:0] mi_din,
   output logic      [31:0] mi_dout,
   // base block controls
   output logic             soft_reset,
   output logic      [15:0] clk_settings,
   output logic      [3:0]  colid,
   output logic      [3:0]  rowid,
   // transmit side
   input  wire logic        tx_pkt,
   output logic             tx_enable,
   output logic      [3:0]  tx_mode,
   // receive side
   input  wire logic [7:0]  rx_error,
   output logic             rx_enable,
   output logic      [2:0]  rx_mode
);

   // per-block registered readback
   logic [31:0] base_data;
   logic [31:0] tx_data;
   logic [31:0] rx_data;

   // ######################################
   // register blocks
   // ######################################

   // every block sees the whole bus and decodes its own group
   ecfg_base base0 (
      .mi_clk       (mi_clk),
      .hard_reset   (hard_reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .rd_data      (base_data),
      .soft_reset   (soft_reset),
      .clk_settings (clk_settings),
      .colid        (colid),
      .rowid        (rowid)
   );

   ecfg_tx tx0 (
      .mi_clk     (mi_clk),
      .hard_reset (hard_reset),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .tx_pkt     (tx_pkt),
      .rd_data    (tx_data),
      .tx_enable  (tx_enable),
      .tx_mode    (tx_mode)
   );

   ecfg_rx rx0 (
      .mi_clk     (mi_clk),
      .hard_reset (hard_reset),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .rx_error   (rx_error),
      .rd_data    (rx_data),
      .rx_enable  (rx_enable),
      .rx_mode    (rx_mode)
   );

   // readback combiner
   ecfg_mi_mux mux0 (
      .mi_clk     (mi_clk),
      .hard_reset (hard_reset),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .base_data  (base_data),
      .tx_data    (tx_data),
      .rx_data    (rx_data),
      .mi_dout    (mi_dout)
   );

endmodule

`default_nettype wire

// ==== tb/ecfg_props.sv ====
`default_nettype none

module ecfg_props import ecfg_pkg::*; (
   input wire logic        mi_clk,
   input wire logic        hard_reset,
   input wire logic        mi_en,
   input wire logic        mi_we,
   input wire logic [19:0] mi_addr,
   input wire logic [31:0] mi_dout,
   input wire logic        soft_reset,
   input wire logic [15:0] clk_settings,
   input wire logic [3:0]  colid,
   input wire logic [3:0]  rowid,
   input wire logic        tx_enable,
   input wire logic [3:0]  tx_mode,
   input wire logic        rx_enable,
   input wire logic [2:0]  rx_mode
);

   logic rd_strobe;
   int   fail_count = 0;   // assertion failures so far

   assign rd_strobe = mi_en & ~mi_we;   // read in this cycle

   // everything at its reset value in the first cycle out of reset
   reset_state: assert property (@(posedge mi_clk) $fell(hard_reset) |->
      (mi_dout == 32'd0) && !soft_reset && (clk_settings == 16'd0)
      && (colid == default_coreid[5:2]) && (rowid == default_coreid[11:8])
      && !tx_enable && (tx_mode == 4'd0) && !rx_enable && (rx_mode == 3'd0))
      else begin
         $error("outputs not at reset values after hard_reset");
         fail_count++;
      end

   // readback moves only after a read
   dout_hold: assert property (@(posedge mi_clk) disable iff (hard_reset)
      !$past(rd_strobe) |-> $stable(mi_dout))
      else begin
         $error("mi_dout changed without a read");
         fail_count++;
      end

   // groups above rx are unclaimed
   zero_group: assert property (@(posedge mi_clk) disable iff (hard_reset)
      rd_strobe && (mi_addr[19:16] > group_rx) |=> (mi_dout == 32'd0))
      else begin
         $error("read of an unclaimed group returned nonzero data");
         fail_count++;
      end

endmodule

bind ecfg_top ecfg_props props0 (.*);

`default_nettype wire

// ==== tb/ecfg_tb.sv ====
`default_nettype none

module ecfg_tb import ecfg_pkg::*; ();

   logic        mi_clk;
   logic        hard_reset;
   logic        mi_en;
   logic        mi_we;
   logic [19:0] mi_addr;
   logic [31:0] mi_din;
   logic [31:0] mi_dout;
   logic        soft_reset;
   logic [15:0] clk_settings;
   logic [3:0]  colid;
   logic [3:0]  rowid;
   logic        tx_pkt;
   logic        tx_enable;
   logic [3:0]  tx_mode;
   logic [7:0]  rx_error;
   logic        rx_enable;
   logic [2:0]  rx_mode;

   // register model state
   logic        m_reset;
   logic [15:0] m_clk;
   logic [11:0] m_coreid;
   logic [15:0] m_version;
   logic        m_tx_en;
   logic [3:0]  m_tx_mode;
   logic [15:0] m_count;
   logic        m_rx_en;
   logic [2:0]  m_rx_mode;
   logic [7:0]  m_flags;
   logic        model_live = 1'b0;   // low until out of reset
   logic        rd_due = 1'b0;       // read sampled at the last edge
   logic [31:0] exp_q[$];            // expected read data in order

   logic [31:0] lfsr_state = 32'hc942_fc5d;
   int          err_count = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          test_len[5] = '{20, 80, 40, 66000, 80};   // rough cycles per test

   ecfg_top dut0 (
      .mi_clk       (mi_clk),
      .hard_reset   (hard_reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .soft_reset   (soft_reset),
      .clk_settings (clk_settings),
      .colid        (colid),
      .rowid        (rowid),
      .tx_pkt       (tx_pkt),
      .tx_enable    (tx_enable),
      .tx_mode      (tx_mode),
      .rx_error     (rx_error),
      .rx_enable    (rx_enable),
      .rx_mode      (rx_mode)
   );

   initial begin
      mi_clk = 1'b0;
      forever #20 mi_clk = ~mi_clk;
   end

   // ######################################
   // helpers
   // ######################################

   function automatic logic [19:0] reg_addr(input logic [3:0] grp, input logic [4:0] idx);
      return {grp, 9'd0, idx, 2'b00};   // group in 19:16 and word index in 6:2
   endfunction

   // 32-bit fibonacci with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = 32'd0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};   // one step per bit
      end
   endtask

   // expected read data from the model state before the edge
   function automatic logic [31:0] ref_read(input logic [19:0] addr);
      logic [3:0]  grp;
      logic [4:0]  idx;
      logic [31:0] val;
      grp = addr[19:16];
      idx = addr[6:2];
      val = 32'd0;   // unclaimed group or index
      if (grp == group_base) begin
         case (idx)
            el_reset:   val = {31'd0, m_reset};
            el_clk:     val = {16'd0, m_clk};
            el_chipid:  val = {20'd0, m_coreid};
            el_version: val = {16'd0, m_version};
            default:    val = 32'd0;
         endcase
      end else if (grp == group_tx) begin
         if (idx == link_cfg) val = {24'd0, m_tx_mode, 3'd0, m_tx_en};
         else if (idx == link_stat) val = {16'd0, m_count};
      end else if (grp == group_rx) begin
         if (idx == link_cfg) val = {28'd0, m_rx_mode, m_rx_en};
         else if (idx == link_stat) val = {24'd0, m_flags};
      end
      return val;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
         err_count++;
      end
   endtask

   // one bus cycle with everything driven on the falling edge
   task automatic drive_cycle(input logic en, input logic we, input logic [19:0] addr,
                              input logic [31:0] din, input logic pkt,
                              input logic [7:0] err);
      @(negedge mi_clk);
      mi_en    = en;
      mi_we    = we;
      mi_addr  = addr;
      mi_din   = din;
      tx_pkt   = pkt;
      rx_error = err;
   endtask

   task automatic bus_write(input logic [19:0] addr, input logic [31:0] data);
      drive_cycle(1'b1, 1'b1, addr, data, 1'b0, 8'd0);
   endtask

   task automatic bus_read(input logic [19:0] addr);
      drive_cycle(1'b1, 1'b0, addr, 32'd0, 1'b0, 8'd0);
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b0, 1'b0, 20'd0, 32'd0, 1'b0, 8'd0);
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      int errs;
      @(posedge mi_clk);   // compare runs on negedges so the counts are settled here
      errs = err_count - errs_before;
      if (errs == 0) begin
         $display("test %0d %s: ok", num, name);
         tests_ok++;
      end else begin
         $display("test %0d %s: %0d errors", num, name, errs);
         tests_bad++;
      end
   endtask

   // ######################################
   // model and compare
   // ######################################

   always @(posedge mi_clk) begin : model
      logic [3:0] grp;
      logic [4:0] idx;
      logic       wr;
      logic [7:0] clr;
      if (hard_reset) begin
         m_reset    = 1'b0;
         m_clk      = 16'd0;
         m_coreid   = default_coreid;
         m_version  = default_version;
         m_tx_en    = 1'b0;
         m_tx_mode  = 4'd0;
         m_count    = 16'd0;
         m_rx_en    = 1'b0;
         m_rx_mode  = 3'd0;
         m_flags    = 8'd0;
         rd_due     = 1'b0;
         model_live = 1'b0;
         exp_q.delete();
      end else begin
         grp    = mi_addr[19:16];
         idx    = mi_addr[6:2];
         wr     = mi_en & mi_we;
         rd_due = mi_en & ~mi_we;
         if (rd_due) exp_q.push_back(ref_read(mi_addr));
         // a packet in the stat write cycle leaves one
         if (wr && grp == group_tx && idx == link_stat) m_count = {15'd0, tx_pkt};
         else if (tx_pkt && m_count != count_max) m_count = m_count + 16'd1;
         clr = (wr && grp == group_rx && idx == link_stat) ? mi_din[7:0] : 8'd0;
         m_flags = (m_flags & ~clr) | rx_error;   // set beats clear
         if (wr && grp == group_base) begin
            case (idx)
               el_reset:   m_reset = mi_din[0];
               el_clk:     m_clk = mi_din[15:0];
               el_chipid:  m_coreid = mi_din[11:0];
               el_version: m_version = mi_din[15:0];
               default:    ;   // unused index
            endcase
         end
         if (wr && grp == group_tx && idx == link_cfg) begin
            m_tx_en   = mi_din[0];
            m_tx_mode = mi_din[7:4];
         end
         if (wr && grp == group_rx && idx == link_cfg) begin
            m_rx_en   = mi_din[0];
            m_rx_mode = mi_din[3:1];
         end
         model_live = 1'b1;
      end
   end

   // read data one cycle after the read and controls every cycle
   always @(negedge mi_clk) begin : compare
      logic [31:0] exp_data;
      if (model_live) begin
         if (rd_due) begin
            exp_data = exp_q.pop_front();
            check_value("mi_dout", exp_data, mi_dout);
         end
         check_value("soft_reset", m_reset, soft_reset);
         check_value("clk_settings", m_clk, clk_settings);
         check_value("colid", m_coreid[5:2], colid);
         check_value("rowid", m_coreid[11:8], rowid);
         check_value("tx_enable", m_tx_en, tx_enable);
         check_value("tx_mode", m_tx_mode, tx_mode);
         check_value("rx_enable", m_rx_en, rx_enable);
         check_value("rx_mode", m_rx_mode, rx_mode);
      end
   end

   always @(posedge mi_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_count);
         $display("test failed");
         $finish;
      end
   end

   // ######################################
   // tests
   // ######################################

   task automatic check_reset_values();
      for (int i = 0; i < 4; i++) bus_read(reg_addr(group_base, 5'(i)));
      for (int i = 0; i < 2; i++) begin
         bus_read(reg_addr(group_tx, 5'(i)));
         bus_read(reg_addr(group_rx, 5'(i)));
      end
      idle_cycle();
   endtask

   task automatic write_read_all();
      logic [19:0] addrs[6];
      logic [31:0] data;
      addrs = '{reg_addr(group_base, el_reset), reg_addr(group_base, el_clk),
                reg_addr(group_base, el_chipid), reg_addr(group_base, el_version),
                reg_addr(group_tx, link_cfg), reg_addr(group_rx, link_cfg)};
      for (int r = 0; r < 4; r++) begin
         for (int k = 0; k < 6; k++) begin
            rand_bits(32, data);
            bus_write(addrs[k], data);
            bus_read(addrs[k]);   // masked to the register width
         end
      end
      idle_cycle();
   endtask

   task automatic read_back_to_back();
      logic [31:0] pick;
      logic [3:0]  grp;
      bus_write(reg_addr(group_tx, link_cfg), 32'h0000_00a1);
      for (int r = 0; r < 3; r++) begin
         rand_bits(5, pick);
         bus_read(reg_addr(group_base, el_chipid));
         bus_read(reg_addr(group_tx, link_cfg));
         bus_read(reg_addr(group_rx, link_cfg));
         bus_read(reg_addr(group_base, 5'(pick) | 5'd4));   // index 4 and up unused
         bus_read(reg_addr(group_tx, 5'(pick) | 5'd2));     // link index 2 and up
         rand_bits(4, pick);
         grp = pick[3:0];
         if (grp < 4'd3) grp = grp + 4'd3;   // unclaimed group
         bus_read(reg_addr(grp, 5'd0));
         bus_read(reg_addr(group_base, el_version));
      end
      idle_cycle();
   endtask

   task automatic count_packets();
      logic [31:0] n;
      logic [19:0] stat;
      stat = reg_addr(group_tx, link_stat);
      bus_write(stat, 32'd0);
      rand_bits(6, n);
      repeat (n) drive_cycle(1'b0, 1'b0, 20'd0, 32'd0, 1'b1, 8'd0);
      bus_read(stat);
      drive_cycle(1'b1, 1'b0, stat, 32'd0, 1'b1, 8'd0);   // read sees count before pulse
      drive_cycle(1'b1, 1'b1, stat, 32'hffff_ffff, 1'b1, 8'd0);   // clear and count
      bus_read(stat);
      // long burst runs into saturation
      repeat (int'(count_max) + 16) drive_cycle(1'b0, 1'b0, 20'd0, 32'd0, 1'b1, 8'd0);
      bus_read(stat);
      bus_write(stat, 32'd0);
      bus_read(stat);
      idle_cycle();
   endtask

   task automatic stick_and_clear_errors();
      logic [31:0] pulses;
      logic [31:0] mask;
      logic [19:0] stat;
      stat = reg_addr(group_rx, link_stat);
      bus_write(stat, 32'h0000_00ff);
      for (int r = 0; r < 4; r++) begin
         for (int c = 0; c < 6; c++) begin
            rand_bits(8, pulses);
            rand_bits(8, mask);
            drive_cycle(1'b0, 1'b0, 20'd0, 32'd0, 1'b0, pulses[7:0] & mask[7:0]);   // sparse
         end
         bus_read(stat);
         rand_bits(8, mask);
         rand_bits(8, pulses);
         // some pulses land on bits being cleared
         drive_cycle(1'b1, 1'b1, stat, mask, 1'b0, pulses[7:0] & mask[7:0]);
         bus_read(stat);
         idle_cycle();
      end
   endtask

   // ######################################
   // main sequence
   // ######################################

   initial begin
      int errs_before;
      foreach (test_len[i]) cycle_limit += test_len[i];
      cycle_limit = 2 * cycle_limit + 50;
      hard_reset = 1'b1;
      mi_en      = 1'b0;
      mi_we      = 1'b0;
      mi_addr    = 20'd0;
      mi_din     = 32'd0;
      tx_pkt     = 1'b0;
      rx_error   = 8'd0;
      repeat (2) @(posedge mi_clk);
      @(negedge mi_clk);
      hard_reset = 1'b0;

      errs_before = err_count;
      check_reset_values();
      report_test(1, "reset values", errs_before);
      errs_before = err_count;
      write_read_all();
      report_test(2, "write and read back", errs_before);
      errs_before = err_count;
      read_back_to_back();
      report_test(3, "back-to-back reads", errs_before);
      errs_before = err_count;
      count_packets();
      report_test(4, "packet counter", errs_before);
      errs_before = err_count;
      stick_and_clear_errors();
      report_test(5, "sticky error flags", errs_before);

      if (exp_q.size() != 0) begin
         $display("%0d reads never got their data checked", exp_q.size());
         err_count++;
      end
      if (dut0.props0.fail_count != 0) begin
         $display("%0d bound assertions failed", dut0.props0.fail_count);
         err_count += dut0.props0.fail_count;
      end
      $display("summary: %0d ok, %0d with errors, %0d check errors",
               tests_ok, tests_bad, err_count);
      if (err_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/ecfg_pkg.sv
verilog/ecfg_base.sv
verilog/ecfg_tx.sv
verilog/ecfg_rx.sv
verilog/ecfg_mi_mux.sv
verilog/ecfg_top.sv
tb/ecfg_props.sv
tb/ecfg_tb.sv

// ==== Bender.yml ====
package:
  name: ecfg

sources:
  # register blocks, package first
  - target: any(rtl, simulation, synthesis)
    files:
      - verilog/ecfg_pkg.sv
      - verilog/ecfg_base.sv
      - verilog/ecfg_tx.sv
      - verilog/ecfg_rx.sv
      - verilog/ecfg_mi_mux.sv
      - verilog/ecfg_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/ecfg_props.sv
      - tb/ecfg_tb.sv
